/* reluLayer_macros.svh */
`ifndef RELULAYER_MACROS_SVH
`define RELULAYER_MACROS_SVH

// Layer shape.
`define NUM_NEURONS 4
`define NUM_INPUTS 10

// Word sizes.
`define DATA_W 16
`define ADR_W 8
`define WEIGHT_DEPTH 64

// Q8.8 fraction bits.
`define FRAC_W 8

// Wishbone word address map.
`define ACT_BASE 8'h40
`define CTRL_ADR 8'h50
`define OUT_BASE 8'h58

`endif

/* reluLayerPkg.sv */
`default_nettype none

`include "reluLayer_macros.svh"

package reluLayerPkg;

	// Q8.8 sample and the wide running sum.
	typedef logic signed [`DATA_W-1:0] sample_t;
	typedef logic signed [2*`DATA_W-1:0] accum_t;

	typedef logic [$clog2(`WEIGHT_DEPTH)-1:0] weightAddr_t;

	// One activation per input, shared by every neuron.
	typedef sample_t [`NUM_INPUTS-1:0] activationVector_t;

	// One result per neuron.
	typedef sample_t [`NUM_NEURONS-1:0] resultVector_t;

endpackage

`default_nettype wire

/* weightMemory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module weightMemory
	import reluLayerPkg::*;
(
	input  logic        clk,
	input  logic        wrEn,
	input  weightAddr_t wrAddr,
	input  sample_t     wrData,
	input  logic        rdEn,
	input  weightAddr_t rdAddr,
	output sample_t     rdData
);

	// Weights and biases, eleven words per neuron.
	sample_t mem [`WEIGHT_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	always_ff @(posedge clk)
	begin
		if (rdEn)
			rdData <= mem[rdAddr]; // Holds between reads.
	end

endmodule

`default_nettype wire

/* weightArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module weightArbiter
	import reluLayerPkg::*;
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic [`NUM_NEURONS-1:0]        req,
	input  weightAddr_t [`NUM_NEURONS-1:0] reqAddr,
	output logic [`NUM_NEURONS-1:0]        grant,
	output logic                           rdEn,
	output weightAddr_t                    rdAddr
);

	localparam int PTR_W = $clog2(`NUM_NEURONS);

	logic [PTR_W-1:0] lastGrant;
	logic [PTR_W-1:0] pick;
	logic found;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Search starts one past the last winner.
	always_comb
	begin
		int cand;
		found = 1'b0;
		pick = lastGrant;
		for (int k = 1; k <= `NUM_NEURONS; k++)
		begin
			cand = (int'(lastGrant) + k) % `NUM_NEURONS;
			if (!found && req[cand])
			begin
				found = 1'b1;
				pick = PTR_W'(cand);
			end
		end
	end

	always_comb
	begin
		grant = '0;
		grant[pick] = found; // One-hot or zero.
	end

	assign rdEn = found;
	assign rdAddr = reqAddr[pick];

	always_ff @(posedge clk)
	begin
		if (reset)
			lastGrant <= PTR_W'(`NUM_NEURONS - 1); // First search begins at neuron 0.
		else if (found)
			lastGrant <= pick;
	end

endmodule

`default_nettype wire

/* reluNeuron.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module reluNeuron
	import reluLayerPkg::*;
#(
	parameter int NEURON_INDEX = 0
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  activationVector_t activations,
	output logic              req,
	output weightAddr_t       reqAddr,
	input  logic              grant,
	input  sample_t           rdData,
	output sample_t           result,
	output logic              done
);

	localparam int IDX_W = $clog2(`NUM_INPUTS + 2);
	localparam weightAddr_t BASE_ADDR = weightAddr_t'(NEURON_INDEX * (`NUM_INPUTS + 1));
	localparam accum_t SAT_MAX = accum_t'((1 <<< (`DATA_W - 1)) - 1);
	localparam logic [IDX_W-1:0] BIAS_IDX = IDX_W'(`NUM_INPUTS);

	typedef enum logic [1:0] {IDLE, RUN, FINISH} state_t;

	state_t state;
	logic [IDX_W-1:0] reqIdx; // Next word to request.
	logic [IDX_W-1:0] capIdx; // Next word to accumulate.
	logic capValid;
	accum_t accum;
	accum_t product;
	sample_t scaled;
	accum_t term;

	assign req = (state == RUN) && (reqIdx <= BIAS_IDX);
	assign reqAddr = BASE_ADDR + weightAddr_t'(reqIdx);
	assign done = (state == IDLE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Product keeps bits 23..8, back to Q8.8.
	always_comb
	begin
		product = '0;
		if (capIdx < BIAS_IDX)
			product = rdData * activations[capIdx];
		scaled = product[`DATA_W+`FRAC_W-1:`FRAC_W];
		if (capIdx == BIAS_IDX)
			term = accum_t'(rdData); // Bias goes in unscaled.
		else
			term = accum_t'(scaled);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			reqIdx <= '0;
			capIdx <= '0;
			capValid <= 1'b0;
			result <= '0;
		end
		else
		begin
			capValid <= grant; // Memory answers a cycle after grant.
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= RUN;
						reqIdx <= '0;
						capIdx <= '0;
					end
				end
				RUN:
				begin
					if (grant)
						reqIdx <= reqIdx + 1'b1;
					if (capValid)
					begin
						capIdx <= capIdx + 1'b1;
						if (capIdx == BIAS_IDX)
							state <= FINISH;
					end
				end
				FINISH:
				begin
					if (accum > SAT_MAX)
						result <= sample_t'(SAT_MAX);
					else if (accum < 0)
						result <= '0; // ReLU.
					else
						result <= sample_t'(accum);
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && start)
			accum <= '0;
		else if (state == RUN && capValid)
			accum <= accum + term;
	end

endmodule

`default_nettype wire

/* hostWishbone.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module hostWishbone
	import reluLayerPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	input  logic [`ADR_W-1:0]       adr,
	input  logic [`DATA_W-1:0]      datIn,
	output logic [`DATA_W-1:0]      datOut,
	output logic                    ack,
	output logic                    wrEn,
	output weightAddr_t             wrAddr,
	output sample_t                 wrData,
	output activationVector_t       activations,
	output logic                    start,
	input  logic [`NUM_NEURONS-1:0] done,
	input  resultVector_t           results
);

	logic access;
	logic busy;
	logic isWeight;
	logic isAct;
	logic isCtrl;
	logic isOut;
	logic [`ADR_W-1:0] actOffset;
	logic [`ADR_W-1:0] outOffset;
	logic [`DATA_W-1:0] readValue;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode.
	assign access = cyc && stb && !ack; // New request, not yet acknowledged.
	assign busy = start || !(&done);
	assign actOffset = adr - `ACT_BASE;
	assign outOffset = adr - `OUT_BASE;
	assign isWeight = (adr < `ADR_W'(`WEIGHT_DEPTH));
	assign isAct = (adr >= `ACT_BASE) && (actOffset < `ADR_W'(`NUM_INPUTS));
	assign isCtrl = (adr == `CTRL_ADR);
	assign isOut = (adr >= `OUT_BASE) && (outOffset < `ADR_W'(`NUM_NEURONS));

	assign wrEn = access && we && isWeight && !busy;
	assign wrAddr = weightAddr_t'(adr);
	assign wrData = datIn;

	always_comb
	begin
		readValue = '0; // Unmapped and weight reads.
		if (isCtrl)
			readValue = {{(`DATA_W-1){1'b0}}, busy};
		else if (isAct)
			readValue = activations[actOffset];
		else if (isOut)
			readValue = results[outOffset];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			ack <= access;
			start <= access && we && isCtrl && datIn[0] && !busy;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access && we && isAct && !busy)
			activations[actOffset] <= datIn;
		if (access && !we)
			datOut <= readValue;
	end

endmodule

`default_nettype wire

/* reluLayer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module reluLayer
	import reluLayerPkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  logic [`ADR_W-1:0]  adr,
	input  logic [`DATA_W-1:0] datIn,
	output logic [`DATA_W-1:0] datOut,
	output logic               ack
);

	logic wrEn;
	weightAddr_t wrAddr;
	sample_t wrData;
	activationVector_t activations;
	logic start;
	logic [`NUM_NEURONS-1:0] done;
	resultVector_t results;
	logic [`NUM_NEURONS-1:0] req;
	weightAddr_t [`NUM_NEURONS-1:0] reqAddr;
	logic [`NUM_NEURONS-1:0] grant;
	logic rdEn;
	weightAddr_t rdAddr;
	sample_t rdData;

	hostWishbone hostWishbone_inst (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.activations(activations),
		.start(start),
		.done(done),
		.results(results)
	);

	weightMemory weightMemory_inst (
		.clk(clk),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	weightArbiter weightArbiter_inst (
		.clk(clk),
		.reset(reset),
		.req(req),
		.reqAddr(reqAddr),
		.grant(grant),
		.rdEn(rdEn),
		.rdAddr(rdAddr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Neuron engines, all reading the shared rdData bus.
	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : neuronGen
		reluNeuron #(
			.NEURON_INDEX(n)
		) reluNeuron_inst (
			.clk(clk),
			.reset(reset),
			.start(start),
			.activations(activations),
			.req(req[n]),
			.reqAddr(reqAddr[n]),
			.grant(grant[n]),
			.rdData(rdData),
			.result(results[n]),
			.done(done[n])
		);
	end

endmodule

`default_nettype wire

/* clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen
#(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0; // Released just after an edge.
	end

endmodule

`default_nettype wire

/* reluLayer_properties.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module reluLayer_properties
(
	input logic                    clk,
	input logic                    reset,
	input logic                    cyc,
	input logic                    stb,
	input logic                    ack,
	input logic                    start,
	input logic [`NUM_NEURONS-1:0] done,
	input logic [`NUM_NEURONS-1:0] req,
	input logic [`NUM_NEURONS-1:0] grant
);

	logic busy;

	assign busy = start || !(&done);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone handshake.
	ackSinglePulse: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held high for more than one cycle");

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb))
		else $error("ack raised without cyc and stb in the cycle before");

	idleAfterReset: assert property (@(posedge clk) reset |=> !ack && !busy)
		else $error("ack or busy high right after reset");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Weight memory arbitration.
	grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("more than one grant in a cycle");

	grantToRequester: assert property (@(posedge clk) disable iff (reset)
		(grant & ~req) == '0)
		else $error("grant given to a neuron that is not requesting");

	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : waitGen
		logic [2:0] waitCount; // Cycles spent requesting without grant.

		always_ff @(posedge clk)
		begin
			if (reset || !req[n] || grant[n])
				waitCount <= '0;
			else
				waitCount <= waitCount + 1'b1;
		end

		requestServed: assert property (@(posedge clk) disable iff (reset)
			waitCount < 3'(`NUM_NEURONS))
			else $error("neuron %0d request not granted in time", n);
	end

endmodule

bind reluLayer reluLayer_properties reluLayer_properties_inst (
	.clk(clk),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.start(start),
	.done(done),
	.req(req),
	.grant(grant)
);

`default_nettype wire

/* reluLayer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reluLayer_macros.svh"

module reluLayer_tb
	import reluLayerPkg::*;
();

	localparam int DRIVE_DELAY = 2;
	localparam int WORDS_PER_NEURON = `NUM_INPUTS + 1;
	localparam int TIMEOUT_CYCLES = 4000; // Several times the full test length.

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [`ADR_W-1:0] adr;
	logic [`DATA_W-1:0] datIn;
	logic [`DATA_W-1:0] datOut;
	logic ack;

	integer seed = 32'h30e1_0a9f;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	sample_t weights [`WEIGHT_DEPTH]; // Model copy of what was loaded.
	sample_t acts [`NUM_INPUTS];
	logic [`DATA_W-1:0] readData;

	clockGen #(.PERIOD(20), .RESET_CYCLES(5)) clockGen_inst (.clk(clk), .reset(reset));

	reluLayer reluLayer_inst (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus access.
	task automatic waitAck();
		do
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while (!ack);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic writeWord(input logic [`ADR_W-1:0] address, input logic [`DATA_W-1:0] data);
		@(posedge clk);
		#DRIVE_DELAY;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = address;
		datIn = data;
		waitAck();
	endtask

	task automatic readWord(input logic [`ADR_W-1:0] address, output logic [`DATA_W-1:0] data);
		@(posedge clk);
		#DRIVE_DELAY;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = address;
		waitAck();
		data = datOut;
	endtask

	task automatic checkValue(input string testName, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("ERROR %s: expected %h, actual %h", testName, expected, actual);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference neuron with Q8.8 products cut to bits 23..8, then bias and clamp.
	function automatic sample_t expectedResult(input int n);
		int sum;
		logic signed [31:0] prod;
		logic signed [15:0] kept;
		sample_t value;
		sum = 0;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			prod = int'(weights[n * WORDS_PER_NEURON + i]) * int'(acts[i]);
			kept = prod[23:8];
			sum += int'(kept);
		end
		sum += int'(weights[n * WORDS_PER_NEURON + `NUM_INPUTS]);
		if (sum > 32767)
			value = 16'sh7fff;
		else if (sum < 0)
			value = '0;
		else
			value = sample_t'(sum);
		return value;
	endfunction

	function automatic sample_t randomSample();
		return sample_t'($random(seed) % 513); // Within +-2.0.
	endfunction

	task automatic randomLayer();
		for (int k = 0; k < `NUM_NEURONS * WORDS_PER_NEURON; k++)
			weights[k] = randomSample();
		for (int i = 0; i < `NUM_INPUTS; i++)
			acts[i] = randomSample();
	endtask

	task automatic loadLayer();
		for (int k = 0; k < `NUM_NEURONS * WORDS_PER_NEURON; k++)
			writeWord(`ADR_W'(k), weights[k]);
		for (int i = 0; i < `NUM_INPUTS; i++)
			writeWord(`ACT_BASE + `ADR_W'(i), acts[i]);
	endtask

	task automatic waitIdle();
		do
			readWord(`CTRL_ADR, readData);
		while (readData[0]);
	endtask

	task automatic runPass();
		writeWord(`CTRL_ADR, 16'h0001);
		waitIdle();
	endtask

	task automatic checkResults(input string testName);
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			readWord(`OUT_BASE + `ADR_W'(n), readData);
			checkValue(testName, expectedResult(n), readData);
		end
	endtask

	task automatic checkActivations(input string testName);
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			readWord(`ACT_BASE + `ADR_W'(i), readData);
			checkValue(testName, acts[i], readData);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		wait (!reset);

		// Idle state after reset.
		checkValue("reset ack", '0, `DATA_W'(ack));
		readWord(`CTRL_ADR, readData);
		checkValue("reset busy", '0, readData);
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			readWord(`OUT_BASE + `ADR_W'(n), readData);
			checkValue("reset result", '0, readData);
		end

		randomLayer();
		loadLayer();
		runPass();
		checkResults("random pass");
		checkActivations("activation readback");

		// Biases far below any reachable sum.
		randomLayer();
		for (int n = 0; n < `NUM_NEURONS; n++)
			weights[n * WORDS_PER_NEURON + `NUM_INPUTS] = 16'sh9c00;
		loadLayer();
		runPass();
		checkResults("negative clamp");

		// Each product is 64.0 and the sum passes the Q8.8 range.
		for (int k = 0; k < `NUM_NEURONS * WORDS_PER_NEURON; k++)
			weights[k] = 16'sh2000;
		for (int i = 0; i < `NUM_INPUTS; i++)
			acts[i] = 16'sh0200;
		loadLayer();
		runPass();
		checkResults("saturation");

		// Writes during a pass must not land.
		randomLayer();
		loadLayer();
		writeWord(`CTRL_ADR, 16'h0001);
		writeWord(`ADR_W'((`NUM_NEURONS - 1) * WORDS_PER_NEURON + `NUM_INPUTS), 16'h7fff);
		writeWord(`ACT_BASE, ~acts[0]);
		writeWord(`CTRL_ADR, 16'h0001);
		waitIdle();
		checkResults("busy writes");
		checkActivations("busy activation");
		runPass(); // Memory still holds the old data.
		checkResults("busy writes second pass");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* reluLayer.f */
+incdir+.
reluLayerPkg.sv
weightMemory.sv
weightArbiter.sv
reluNeuron.sv
hostWishbone.sv
reluLayer.sv
clockGen.sv
reluLayer_properties.sv
reluLayer_tb.sv

/* Makefile */
TOP = reluLayer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f reluLayer.f --Mdir obj_dir -o simv

run: build
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "^All tests passed$$"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f reluLayer.f

clean:
	rm -rf obj_dir
